/* project.f */
+incdir+.
mem_pkg.sv
mem_lane_if.sv
byte_lane_ram.sv
data_memory.sv
console_tx_queue.sv
mem_stage_top.sv
tb_mem_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_stage
FILE_LIST = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

SOURCES = $(filter-out +incdir+%,$(shell cat $(FILE_LIST))) tb_mem_tasks.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mem_tasks.svh */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

function automatic logic [XLEN-1:0] random_ram_addr();
   return XLEN'($urandom) & XLEN'(MEM_BYTES - 1);   // stays below the console
endfunction

// the model follows every core store that misses the console
task automatic core_store(input logic [XLEN-1:0] a, input mem_size_e sz,
                          input logic [XLEN-1:0] d);
   addr  = a;
   size  = sz;
   wdata = d;
   we    = 1'b1;
   if (a != CONSOLE_ADDR) begin
      model_store(a, sz, d);
   end
   @(negedge clk);
   we = 1'b0;
endtask

// writeback triple of a load shows up one cycle later
task automatic core_load_check(input logic [XLEN-1:0] a, input mem_size_e sz);
   logic [XLEN-1:0]       expected;
   logic [REG_ADDR_W-1:0] rd;
   expected   = model_load(a, sz);
   rd         = REG_ADDR_W'($urandom);
   addr       = a;
   size       = sz;
   rd_in      = rd;
   mem_to_reg = 1'b1;
   reg_we_in  = 1'b1;
   @(negedge clk);
   if (reg_wdata !== expected) report_mismatch("reg_wdata", reg_wdata, expected);
   if (reg_rd !== rd) report_mismatch("reg_rd", XLEN'(reg_rd), XLEN'(rd));
   if (reg_we !== 1'b1) report_mismatch("reg_we", XLEN'(reg_we), XLEN'(1));
   mem_to_reg = 1'b0;
   reg_we_in  = 1'b0;
endtask

task automatic test_word_store_load();
   logic [XLEN-1:0] a;
   for (int i = 0; i < 4; i++) begin
      a = random_ram_addr() & ~32'd3;
      core_store(a, SIZE_WORD, $urandom);
      core_load_check(a, SIZE_WORD);
   end
endtask

// sub-word store over a known word and then every load size at every offset
task automatic test_sub_word();
   logic [XLEN-1:0] base;
   mem_size_e       st_size;
   for (int s = 0; s < 2; s++) begin
      st_size = (s == 0) ? SIZE_BYTE : SIZE_HALF;
      for (int off = 0; off < 4; off++) begin
         base = random_ram_addr() & ~32'd3;
         core_store(base, SIZE_WORD, $urandom);
         core_store(base + XLEN'(off), st_size, $urandom);
         for (int l = 0; l < 3; l++) begin
            for (int lo = 0; lo < 4; lo++) begin
               core_load_check(base + XLEN'(lo), mem_size_e'(l));
            end
         end
      end
   end
endtask

task automatic test_alu_and_run();
   logic [XLEN-1:0]       alu;
   logic [REG_ADDR_W-1:0] rd;
   for (int i = 0; i < 4; i++) begin
      alu        = $urandom;
      rd         = REG_ADDR_W'($urandom);
      alu_result = alu;
      rd_in      = rd;
      addr       = random_ram_addr();   // load data must not matter
      reg_we_in  = 1'b1;
      @(negedge clk);
      if (reg_wdata !== alu) report_mismatch("reg_wdata", reg_wdata, alu);
      if (reg_rd !== rd) report_mismatch("reg_rd", XLEN'(reg_rd), XLEN'(rd));
      if (reg_we !== 1'b1) report_mismatch("reg_we", XLEN'(reg_we), XLEN'(1));
   end
   run = 1'b0;   // halted core with a write requested
   for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      if (reg_we !== 1'b0) report_mismatch("reg_we", XLEN'(reg_we), XLEN'(0));
   end
   run       = 1'b1;
   reg_we_in = 1'b0;
   @(negedge clk);
endtask

task automatic test_host_preload();
   logic [XLEN-1:0] addrs [8];
   logic [XLEN-1:0] d;
   for (int i = 0; i < 8; i++) begin
      addrs[i]  = random_ram_addr() & ~32'd3;
      d         = $urandom;
      host_addr = addrs[i];
      host_data = d;
      host_we   = 1'b1;
      model_store(addrs[i], SIZE_WORD, d);
      @(negedge clk);
   end
   host_we = 1'b0;
   for (int i = 0; i < 8; i++) begin
      core_load_check(addrs[i], SIZE_WORD);
   end
   // same-cycle collision where the core store must win
   d         = $urandom;
   host_addr = addrs[0];
   host_data = ~d;
   host_we   = 1'b1;
   core_store(addrs[0], SIZE_WORD, d);
   host_we = 1'b0;
   core_load_check(addrs[0], SIZE_WORD);
   if (reg_wdata !== d) report_mismatch("reg_wdata", reg_wdata, d);
endtask

task automatic wait_rx_count(input int n);
   int cycles;
   cycles = 0;
   while (rx_bytes.size() < n && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
   end
   if (rx_bytes.size() < n) begin
      report_failure($sformatf("timed out waiting for console byte %0d", n));
   end
endtask

// nothing beyond n bytes may come out while credits are held back
task automatic expect_rx_count(input int n);
   int cycles;
   cycles = 0;
   while (rx_bytes.size() <= n && cycles < QUIET_CYCLES) begin
      @(negedge clk);
      cycles++;
   end
   if (rx_bytes.size() != n) begin
      report_failure($sformatf("%0d console bytes sent, %0d allowed", rx_bytes.size(), n));
   end
endtask

task automatic return_credit();
   tx_credit = 1'b1;
   @(negedge clk);
   tx_credit = 1'b0;
endtask

task automatic check_rx_order();
   for (int i = 0; i < rx_bytes.size() && i < sent_bytes.size(); i++) begin
      if (rx_bytes[i] !== sent_bytes[i]) begin
         report_mismatch("tx_data", XLEN'(rx_bytes[i]), XLEN'(sent_bytes[i]));
      end
   end
endtask

task automatic test_console_credits();
   logic [XLEN-1:0] d;
   rx_bytes.delete();
   sent_bytes.delete();
   for (int i = 0; i < TX_CREDITS + 2; i++) begin
      d = $urandom;
      core_store(CONSOLE_ADDR, SIZE_BYTE, d);
      sent_bytes.push_back(d[7:0]);
   end
   wait_rx_count(TX_CREDITS);
   expect_rx_count(TX_CREDITS);
   for (int i = TX_CREDITS; i < TX_CREDITS + 2; i++) begin
      return_credit();
      wait_rx_count(i + 1);
      expect_rx_count(i + 1);
   end
   if (overflow !== 1'b0) report_mismatch("overflow", XLEN'(overflow), XLEN'(0));
   check_rx_order();
endtask

task automatic test_console_overflow();
   logic [XLEN-1:0] d;
   apply_reset();   // credits back to the full count
   rx_bytes.delete();
   sent_bytes.delete();
   for (int i = 0; i < TX_CREDITS + QUEUE_DEPTH; i++) begin
      d = $urandom;
      core_store(CONSOLE_ADDR, SIZE_BYTE, d);
      sent_bytes.push_back(d[7:0]);
   end
   wait_rx_count(TX_CREDITS);
   if (overflow !== 1'b0) report_mismatch("overflow", XLEN'(overflow), XLEN'(0));
   for (int i = 0; i < 2; i++) begin
      core_store(CONSOLE_ADDR, SIZE_BYTE, $urandom);   // dropped while the queue is full
   end
   if (overflow !== 1'b1) report_mismatch("overflow", XLEN'(overflow), XLEN'(1));
   for (int i = TX_CREDITS; i < TX_CREDITS + QUEUE_DEPTH; i++) begin
      return_credit();
      wait_rx_count(i + 1);
   end
   // receiver frees its whole buffer and any dropped byte would get out now
   for (int i = 0; i < TX_CREDITS; i++) begin
      return_credit();
   end
   expect_rx_count(TX_CREDITS + QUEUE_DEPTH);
   check_rx_order();
endtask

`endif

/* tb_mem_stage.sv */
`default_nettype none

module tb_mem_stage;
   import mem_pkg::*;

   localparam int ADDR_BITS    = 12;
   localparam int QUEUE_DEPTH  = 4;
   localparam int TX_CREDITS   = 2;
   localparam int MEM_BYTES    = 2 ** ADDR_BITS;
   localparam int WAIT_LIMIT   = 50;   // cycles before a wait gives up
   localparam int QUIET_CYCLES = 12;

   logic                  clk;
   logic                  arst_n;
   logic                  run;
   logic [XLEN-1:0]       addr;
   mem_size_e             size;
   logic [XLEN-1:0]       wdata;
   logic                  we;
   logic                  mem_to_reg;
   logic [XLEN-1:0]       alu_result;
   logic [REG_ADDR_W-1:0] rd_in;
   logic                  reg_we_in;
   logic [XLEN-1:0]       host_addr;
   logic [XLEN-1:0]       host_data;
   logic                  host_we;
   logic [XLEN-1:0]       reg_wdata;
   logic [REG_ADDR_W-1:0] reg_rd;
   logic                  reg_we;
   logic [7:0]            tx_data;
   logic                  tx_valid;
   logic                  tx_credit;
   logic                  overflow;

   logic [7:0] ref_mem [MEM_BYTES];   // byte-addressed reference memory
   logic [7:0] rx_bytes [$];          // bytes seen on the console output
   logic [7:0] sent_bytes [$];        // console bytes expected to come out
   int         n_errors;
   int         n_failures;

   mem_stage_top #(
      .ADDR_BITS   (ADDR_BITS),
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .TX_CREDITS  (TX_CREDITS)
   ) i_mem_stage_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .run        (run),
      .addr       (addr),
      .size       (size),
      .wdata      (wdata),
      .we         (we),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .host_addr  (host_addr),
      .host_data  (host_data),
      .host_we    (host_we),
      .reg_wdata  (reg_wdata),
      .reg_rd     (reg_rd),
      .reg_we     (reg_we),
      .tx_data    (tx_data),
      .tx_valid   (tx_valid),
      .tx_credit  (tx_credit),
      .overflow   (overflow)
   );

   always begin
      #5 clk = ~clk;
   end

   // one byte per cycle with tx_valid high
   always @(negedge clk) begin
      if (arst_n && tx_valid) begin
         rx_bytes.push_back(tx_data);
      end
   end

   function automatic int size_bytes(input mem_size_e sz);
      case (sz)
         SIZE_BYTE: return 1;
         SIZE_HALF: return 2;
         default:   return 4;
      endcase
   endfunction

   // byte j of the value lands in lane offset+j, past lane 3 it is lost
   function automatic void model_store(input logic [XLEN-1:0] a, input mem_size_e sz,
                                       input logic [XLEN-1:0] d);
      int word_base;
      int off;
      word_base = int'(a[ADDR_BITS-1:2]) * 4;
      off       = int'(a[1:0]);
      for (int j = 0; j < size_bytes(sz); j++) begin
         if (off + j < 4) begin
            ref_mem[word_base + off + j] = d[8*j +: 8];
         end
      end
   endfunction

   function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] a,
                                                  input mem_size_e sz);
      logic [XLEN-1:0] result;
      int              word_base;
      int              off;
      result    = '0;   // zero extension and console reads
      word_base = int'(a[ADDR_BITS-1:2]) * 4;
      off       = int'(a[1:0]);
      if (a != CONSOLE_ADDR) begin
         for (int j = 0; j < size_bytes(sz); j++) begin
            if (off + j < 4) begin
               result[8*j +: 8] = ref_mem[word_base + off + j];
            end
         end
      end
      return result;
   endfunction

   task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                  input logic [XLEN-1:0] expected);
      n_errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
   endtask

   task automatic report_failure(input string what);
      n_failures++;
      $display("failure at %0t: %s", $time, what);
   endtask

   task automatic apply_reset();
      arst_n = 1'b0;
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
   endtask

   `include "tb_mem_tasks.svh"

   initial begin
      void'($urandom(32'hfacc6eca));
      clk        = 1'b0;
      arst_n     = 1'b0;
      run        = 1'b0;
      addr       = '0;
      size       = SIZE_WORD;
      wdata      = '0;
      we         = 1'b0;
      mem_to_reg = 1'b0;
      alu_result = '0;
      rd_in      = '0;
      reg_we_in  = 1'b0;
      host_addr  = '0;
      host_data  = '0;
      host_we    = 1'b0;
      tx_credit  = 1'b0;
      n_errors   = 0;
      n_failures = 0;
      apply_reset();
      run = 1'b1;
      test_word_store_load();
      test_sub_word();
      test_alu_and_run();
      test_host_preload();
      test_console_credits();
      test_console_overflow();
      $display("value errors: %0d, other failures: %0d", n_errors, n_failures);
      if (n_errors == 0 && n_failures == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* mem_stage_top.sv */
`default_nettype none

module mem_stage_top #(
   parameter int ADDR_BITS   = 12,
   parameter int QUEUE_DEPTH = 4,
   parameter int TX_CREDITS  = 2
) (
   input wire                             clk,
   input wire                             arst_n,
   input wire                             run,
   input wire [mem_pkg::XLEN-1:0]         addr,
   input var mem_pkg::mem_size_e          size,
   input wire [mem_pkg::XLEN-1:0]         wdata,
   input wire                             we,
   input wire                             mem_to_reg,
   input wire [mem_pkg::XLEN-1:0]         alu_result,
   input wire [mem_pkg::REG_ADDR_W-1:0]   rd_in,
   input wire                             reg_we_in,
   input wire [mem_pkg::XLEN-1:0]         host_addr,
   input wire [mem_pkg::XLEN-1:0]         host_data,
   input wire                             host_we,
   output logic [mem_pkg::XLEN-1:0]       reg_wdata,
   output logic [mem_pkg::REG_ADDR_W-1:0] reg_rd,
   output logic                           reg_we,
   output logic [7:0]                     tx_data,
   output logic                           tx_valid,
   input wire                             tx_credit,
   output logic                           overflow
);

   logic       push;
   logic [7:0] push_data;
   logic       queue_full;

   mem_lane_if #(.ADDR_BITS(ADDR_BITS)) lane_if [4] ();

   data_memory #(
      .ADDR_BITS(ADDR_BITS)
   ) i_data_memory (
      .clk        (clk),
      .arst_n     (arst_n),
      .run        (run),
      .addr       (addr),
      .size       (size),
      .wdata      (wdata),
      .we         (we),
      .mem_to_reg (mem_to_reg),
      .alu_result (alu_result),
      .rd_in      (rd_in),
      .reg_we_in  (reg_we_in),
      .host_addr  (host_addr),
      .host_data  (host_data),
      .host_we    (host_we),
      .reg_wdata  (reg_wdata),
      .reg_rd     (reg_rd),
      .reg_we     (reg_we),
      .push       (push),
      .push_data  (push_data),
      .queue_full (queue_full),
      .lanes      (lane_if)
   );

   // one byte-wide RAM per lane
   for (genvar k = 0; k < 4; k++) begin : g_lane
      byte_lane_ram #(
         .ADDR_BITS(ADDR_BITS)
      ) i_byte_lane_ram (
         .clk  (clk),
         .lane (lane_if[k])
      );
   end

   console_tx_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .TX_CREDITS  (TX_CREDITS)
   ) i_console_tx_queue (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (push),
      .push_data (push_data),
      .full      (queue_full),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_credit (tx_credit),
      .overflow  (overflow)
   );

endmodule

`default_nettype wire

/* console_tx_queue.sv */
`default_nettype none

module console_tx_queue #(
   parameter int QUEUE_DEPTH = 4,
   parameter int TX_CREDITS  = 2
) (
   input wire         clk,
   input wire         arst_n,
   input wire         push,
   input wire [7:0]   push_data,
   output logic       full,
   output logic [7:0] tx_data,
   output logic       tx_valid,
   input wire         tx_credit,   // one pulse per byte freed by the receiver
   output logic       overflow
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
   localparam int CRD_W = $clog2(TX_CREDITS + 1);

   logic [7:0]       fifo_mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] credits;
   logic             accept;
   logic             pop;

   // wrap at the depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full   = (count == CNT_W'(QUEUE_DEPTH));
   assign accept = push && !full;                     // dropped when full
   assign pop    = (count != '0) && (credits != '0);

   assign tx_valid = pop;
   assign tx_data  = fifo_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (accept) begin
         fifo_mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credits  <= CRD_W'(TX_CREDITS);   // receiver buffer starts empty
         overflow <= 1'b0;
      end else begin
         if (accept) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({accept, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // return and send together cancel out
         case ({tx_credit, pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
         if (push && full) begin
            overflow <= 1'b1;   // sticky until reset
         end
      end
   end

   // receiver never returns more than it was given
   a_credit_max : assert property (
      @(posedge clk) disable iff (!arst_n) credits <= CRD_W'(TX_CREDITS)
   );

   a_valid_needs_credit : assert property (
      @(posedge clk) disable iff (!arst_n) tx_valid |-> credits != '0
   );

endmodule

`default_nettype wire

/* data_memory.sv */
`default_nettype none

module data_memory #(
   parameter int ADDR_BITS = 12
) (
   input wire                            clk,
   input wire                            arst_n,
   input wire                            run,
   // core side
   input wire [mem_pkg::XLEN-1:0]        addr,
   input var mem_pkg::mem_size_e         size,
   input wire [mem_pkg::XLEN-1:0]        wdata,
   input wire                            we,
   input wire                            mem_to_reg,
   input wire [mem_pkg::XLEN-1:0]        alu_result,
   input wire [mem_pkg::REG_ADDR_W-1:0]  rd_in,
   input wire                            reg_we_in,
   // host preload port
   input wire [mem_pkg::XLEN-1:0]        host_addr,
   input wire [mem_pkg::XLEN-1:0]        host_data,
   input wire                            host_we,
   // writeback
   output logic [mem_pkg::XLEN-1:0]      reg_wdata,
   output logic [mem_pkg::REG_ADDR_W-1:0] reg_rd,
   output logic                          reg_we,
   // console queue
   output logic                          push,
   output logic [7:0]                    push_data,
   input wire                            queue_full,
   // byte lanes, lane k holds byte k of the word
   mem_lane_if.stage                     lanes [4]
);
   import mem_pkg::*;

   localparam int WORD_W = ADDR_BITS - 2;

   logic [WORD_W-1:0] word_addr;
   logic [WORD_W-1:0] lane_waddr;
   logic [XLEN-1:0]   lane_wdata;
   logic [3:0]        lane_we;
   logic              is_console;
   logic              ram_store;
   logic [3:0]        size_en;
   logic [3:0]        st_en;
   logic [XLEN-1:0]   st_data;
   logic [XLEN-1:0]   rd_word;
   logic [XLEN-1:0]   rd_shift;
   logic [XLEN-1:0]   load_data;

   assign word_addr  = addr[ADDR_BITS-1:2];
   assign is_console = (addr == CONSOLE_ADDR);
   assign ram_store  = we && !is_console;

   // lane enables before alignment
   always_comb begin
      case (size)
         SIZE_BYTE: size_en = 4'b0001;
         SIZE_HALF: size_en = 4'b0011;
         default:   size_en = 4'b1111;   // word and the unused code
      endcase
   end

   // move enables and data up to the addressed lane, overflow falls off
   assign st_en   = size_en << addr[1:0];
   assign st_data = wdata << {addr[1:0], 3'b000};

   // core store has priority, a colliding host write is lost
   always_comb begin
      lane_waddr = word_addr;
      lane_wdata = st_data;
      lane_we    = 4'b0000;
      if (ram_store) begin
         lane_we = st_en;
      end else if (host_we) begin
         lane_waddr = host_addr[ADDR_BITS-1:2];
         lane_wdata = host_data;
         lane_we    = 4'b1111;
      end
   end

   for (genvar k = 0; k < 4; k++) begin : g_lane
      assign lanes[k].raddr       = word_addr;
      assign lanes[k].waddr       = lane_waddr;
      assign lanes[k].wdata       = lane_wdata[8*k +: 8];
      assign lanes[k].we          = lane_we[k];
      assign rd_word[8*k +: 8]    = lanes[k].rdata;
   end

   // load path, zero extended
   assign rd_shift = rd_word >> {addr[1:0], 3'b000};

   always_comb begin
      if (is_console) begin
         load_data = '0;   // console reads back nothing
      end else begin
         case (size)
            SIZE_BYTE: load_data = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
            SIZE_HALF: load_data = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
            default:   load_data = rd_shift;
         endcase
      end
   end

   // writeback triple
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_we <= 1'b0;
      end else begin
         reg_we <= run && reg_we_in;
      end
   end

   always_ff @(posedge clk) begin
      reg_rd    <= rd_in;
      reg_wdata <= mem_to_reg ? load_data : alu_result;
   end

   // console store, byte goes to the queue at the next edge
   assign push      = we && is_console;
   assign push_data = st_data[7:0];

   // a halted core must not retire a register write
   a_no_we_after_halt : assert property (
      @(posedge clk) disable iff (!arst_n) !run |=> !reg_we
   );

   // the queue fills only from console stores issued here
   a_full_from_push : assert property (
      @(posedge clk) disable iff (!arst_n) $rose(queue_full) |-> $past(push)
   );

endmodule

`default_nettype wire

/* byte_lane_ram.sv */
`default_nettype none

module byte_lane_ram #(
   parameter int ADDR_BITS = 12
) (
   input wire      clk,
   mem_lane_if.ram lane
);
   import mem_pkg::*;

   localparam int ENTRIES = 2 ** (ADDR_BITS - 2);

   logic [XLEN/4-1:0] mem [ENTRIES];

   // write lands at the edge, read sees it from the next cycle on
   always_ff @(posedge clk) begin
      if (lane.we) begin
         mem[lane.waddr] <= lane.wdata;
      end
   end

   assign lane.rdata = mem[lane.raddr];   // asynchronous read

   // an unknown index would corrupt an arbitrary entry
   a_waddr_known : assert property (
      @(posedge clk) lane.we |-> !$isunknown(lane.waddr)
   );

endmodule

`default_nettype wire

/* mem_lane_if.sv */
`default_nettype none

interface mem_lane_if #(
   parameter int ADDR_BITS = 12
) ();
   import mem_pkg::*;

   logic [ADDR_BITS-3:0] raddr;   // word index, byte offset stripped
   logic [ADDR_BITS-3:0] waddr;
   logic [XLEN/4-1:0]    wdata;   // one byte of the word
   logic                 we;
   logic [XLEN/4-1:0]    rdata;

   // memory stage side
   modport stage (
      output raddr,
      output waddr,
      output wdata,
      output we,
      input  rdata
   );

   // storage side
   modport ram (
      input  raddr,
      input  waddr,
      input  wdata,
      input  we,
      output rdata
   );

endinterface

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

   // datapath and address width of the core
   localparam int XLEN = 32;

   // register file index width
   localparam int REG_ADDR_W = 5;

   // console transmit register, stores here bypass the RAM
   localparam logic [XLEN-1:0] CONSOLE_ADDR = 32'h1000_0000;

   // access size as encoded by the decode stage
   // code 3 is not named and is handled like a word
   typedef enum logic [1:0] {
      SIZE_WORD = 2'd0,
      SIZE_BYTE = 2'd1,
      SIZE_HALF = 2'd2
   } mem_size_e;

endpackage

`default_nettype wire
